// ==== common/serbus_pkg.sv ====
// Serial bus shared definitions
package serbus_pkg;

    // slave identity carried in the frame header.
    localparam int ID_W = 3;

    typedef logic [ID_W-1:0] slave_id_t;

    // header bits after the start bit: identity plus direction.
    localparam int HDR_W = ID_W + 1;

    localparam int ACK_TIMEOUT = 64;    // cycles allowed for an answer to begin.

    // line levels.
    localparam logic START_BIT = 1'b0;  // also the acknowledge level.
    localparam logic LINE_IDLE = 1'b1;

endpackage

// ==== common/mem_port_if.sv ====
// Slave to memory port
`timescale 1ns/1ps

interface mem_port_if #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 8
);

    logic              req;     // single-cycle request.
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              done;    // one cycle after req.
    logic [DATA_W-1:0] rdata;

    modport slave (
        output req,
        output we,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport memory (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

// ==== logic/bit_shifter.sv ====
// MSB-first shift register
`timescale 1ns/1ps

module bit_shifter #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             load,
    input  logic [WIDTH-1:0] load_value,
    input  logic             shift,
    input  logic             serial_in,
    output logic             serial_out,
    output logic [WIDTH-1:0] parallel_out,
    output logic             last
);

    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [WIDTH-1:0] sreg;
    logic [CNT_W-1:0] cnt;

    assign serial_out   = sreg[WIDTH-1];
    assign parallel_out = sreg;

    // high on the shift that completes WIDTH bits.
    assign last = shift && (cnt == CNT_W'(WIDTH - 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= '0;
        end else if (shift) begin
            cnt <= last ? '0 : cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sreg <= load_value;
        end else if (shift) begin
            sreg <= (sreg << 1) | WIDTH'(serial_in);  // new bit enters at lsb.
        end
    end

endmodule

// ==== logic/slave_mem.sv ====
// Slave local memory
`timescale 1ns/1ps

module slave_mem #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 8
) (
    input  logic       clk,
    input  logic       rstn,
    mem_port_if.memory port
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [DATA_W-1:0] mem_q [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
            port.done <= 1'b0;
        end else begin
            port.done <= port.req;  // one cycle access.
            if (port.req && port.we) begin
                mem_q[port.addr] <= port.wdata;
            end
        end
    end

    // read data lines up with done.
    always_ff @(posedge clk) begin
        if (port.req) begin
            port.rdata <= mem_q[port.addr];
        end
    end

endmodule

// ==== serial_master/serial_master.sv ====
// Serial bus master
`timescale 1ns/1ps

module serial_master #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 8
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [serbus_pkg::ID_W+ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]                  pwdata,
    output logic [DATA_W-1:0]                  prdata,
    output logic                               pready,
    output logic                               pslverr,
    output logic                               ms_line,
    input  logic                               sl_line
);

    import serbus_pkg::*;

    localparam int HEAD_BITS = HDR_W + ADDR_W;  // identity, direction, address.
    localparam int FRAME_W   = HEAD_BITS + DATA_W;
    localparam int CNT_W     = $clog2(ACK_TIMEOUT + HEAD_BITS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_HEADER,
        S_DATA,
        S_WAIT,
        S_CAPTURE,
        S_DONE
    } state_t;

    state_t             state;
    logic [CNT_W-1:0]   cnt;        // header bits, then answer timeout.
    logic               wr_q;
    logic               err_q;
    logic               setup;
    logic [FRAME_W-1:0] frame_value;
    logic               frame_out;
    logic               frame_last;
    logic               rx_last;
    logic [DATA_W-1:0]  rx_data;

    assign setup = psel && !penable;
    assign frame_value = {paddr[ID_W+ADDR_W-1 -: ID_W], pwrite, paddr[ADDR_W-1:0], pwdata};

    bit_shifter #(.WIDTH(FRAME_W)) frame_shifter (
        .clk          (clk),
        .rstn         (rstn),
        .load         (state == S_IDLE && setup),
        .load_value   (frame_value),
        .shift        (state == S_HEADER || state == S_DATA),
        .serial_in    (LINE_IDLE),
        .serial_out   (frame_out),
        .parallel_out (),
        .last         (frame_last)
    );

    // load here only clears the bit count.
    bit_shifter #(.WIDTH(DATA_W)) rx_shifter (
        .clk          (clk),
        .rstn         (rstn),
        .load         (state == S_IDLE && setup),
        .load_value   ('0),
        .shift        (state == S_CAPTURE),
        .serial_in    (sl_line),
        .serial_out   (),
        .parallel_out (rx_data),
        .last         (rx_last)
    );

    always_comb begin
        case (state)
            S_START:            ms_line = START_BIT;
            S_HEADER, S_DATA:   ms_line = frame_out;
            default:            ms_line = LINE_IDLE;
        endcase
    end

    assign pready  = (state == S_DONE);
    assign pslverr = pready && err_q;
    assign prdata  = (pready && !err_q && !wr_q) ? rx_data : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            cnt   <= '0;
            wr_q  <= 1'b0;
            err_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (setup) begin    // request sampled once here.
                        wr_q  <= pwrite;
                        err_q <= 1'b0;
                        state <= S_START;
                    end
                end
                S_START: begin
                    cnt   <= '0;
                    state <= S_HEADER;
                end
                S_HEADER: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(HEAD_BITS - 1)) begin
                        cnt   <= '0;
                        state <= wr_q ? S_DATA : S_WAIT;
                    end
                end
                S_DATA: begin
                    if (frame_last) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    cnt <= cnt + 1'b1;
                    if (sl_line == START_BIT) begin
                        state <= wr_q ? S_DONE : S_CAPTURE;
                    end else if (cnt == CNT_W'(ACK_TIMEOUT - 1)) begin
                        err_q <= 1'b1;  // nobody answered.
                        state <= S_DONE;
                    end
                end
                S_CAPTURE: begin
                    if (rx_last) begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== serial_slave/serial_slave.sv ====
// Serial bus slave
`timescale 1ns/1ps

module serial_slave #(
    parameter int                    ADDR_W  = 6,
    parameter int                    DATA_W  = 8,
    parameter serbus_pkg::slave_id_t SELF_ID = 1
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      ms_line,
    output logic      sl_out,
    mem_port_if.slave mem
);

    import serbus_pkg::*;

    localparam int CAP_W = ADDR_W + DATA_W;
    localparam int CNT_W = $clog2(CAP_W + ID_W);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ID,
        S_DIR,
        S_RECV,
        S_SKIP,
        S_REQ,
        S_MEM,
        S_ACK,
        S_RSTART,
        S_RDATA
    } state_t;

    state_t            state;
    logic              ms_q;        // registered downstream line.
    slave_id_t         id_q;
    logic              wr_q;
    logic [CNT_W-1:0]  cnt;
    logic [CNT_W-1:0]  field_end;
    logic              cap_last;
    logic [CAP_W-1:0]  cap_data;
    logic              ret_out;
    logic              ret_last;

    // last bit index after the direction bit.
    assign field_end = wr_q ? CNT_W'(CAP_W - 1) : CNT_W'(ADDR_W - 1);

    bit_shifter #(.WIDTH(CAP_W)) cap_shifter (
        .clk          (clk),
        .rstn         (rstn),
        .load         (state == S_IDLE && ms_q == START_BIT),
        .load_value   ('0),
        .shift        (state == S_RECV),
        .serial_in    (ms_q),
        .serial_out   (),
        .parallel_out (cap_data),
        .last         (cap_last)
    );

    bit_shifter #(.WIDTH(DATA_W)) ret_shifter (
        .clk          (clk),
        .rstn         (rstn),
        .load         (state == S_MEM && mem.done && !wr_q),
        .load_value   (mem.rdata),
        .shift        (state == S_RDATA),
        .serial_in    (LINE_IDLE),
        .serial_out   (ret_out),
        .parallel_out (),
        .last         (ret_last)
    );

    // a read frame carries only the address, so it sits in the low bits.
    assign mem.req   = (state == S_REQ);
    assign mem.we    = wr_q;
    assign mem.addr  = wr_q ? cap_data[CAP_W-1 -: ADDR_W] : cap_data[ADDR_W-1:0];
    assign mem.wdata = cap_data[DATA_W-1:0];

    always_comb begin
        case (state)
            S_ACK, S_RSTART:    sl_out = START_BIT;
            S_RDATA:            sl_out = ret_out;
            default:            sl_out = LINE_IDLE;  // released.
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            ms_q  <= LINE_IDLE;
            id_q  <= '0;
            wr_q  <= 1'b0;
            cnt   <= '0;
        end else begin
            ms_q <= ms_line;
            case (state)
                S_IDLE: begin
                    if (ms_q == START_BIT) begin
                        cnt   <= '0;
                        state <= S_ID;
                    end
                end
                S_ID: begin
                    id_q <= {id_q[ID_W-2:0], ms_q};
                    cnt  <= cnt + 1'b1;
                    if (cnt == CNT_W'(ID_W - 1)) begin
                        state <= S_DIR;
                    end
                end
                S_DIR: begin
                    wr_q  <= ms_q;
                    cnt   <= '0;
                    state <= (id_q == SELF_ID) ? S_RECV : S_SKIP;
                end
                S_RECV: begin
                    cnt <= cnt + 1'b1;
                    if (wr_q ? cap_last : (cnt == field_end)) begin
                        state <= S_REQ;
                    end
                end
                S_SKIP: begin   // not ours, let the frame pass.
                    cnt <= cnt + 1'b1;
                    if (cnt == field_end) begin
                        state <= S_IDLE;
                    end
                end
                S_REQ: begin
                    state <= S_MEM;
                end
                S_MEM: begin
                    if (mem.done) begin
                        state <= wr_q ? S_ACK : S_RSTART;
                    end
                end
                S_RDATA: begin
                    if (ret_last) begin
                        state <= S_IDLE;
                    end
                end
                S_RSTART: begin
                    state <= S_RDATA;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/serbus_top.sv ====
// Serial bus subsystem top
`timescale 1ns/1ps

module serbus_top #(
    parameter int ADDR_W = 6,
    parameter int DATA_W = 8
) (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [serbus_pkg::ID_W+ADDR_W-1:0] paddr,
    input  logic [DATA_W-1:0]                  pwdata,
    output logic [DATA_W-1:0]                  prdata,
    output logic                               pready,
    output logic                               pslverr
);

    import serbus_pkg::*;

    logic ms_line;
    logic sl_line;
    logic sl_out_1;
    logic sl_out_2;

    mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_1 ();
    mem_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_2 ();

    assign sl_line = sl_out_1 & sl_out_2;  // wired-and upstream.

    serial_master #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) master_inst (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ms_line (ms_line),
        .sl_line (sl_line)
    );

    serial_slave #(
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W),
        .SELF_ID (slave_id_t'(1))
    ) slave_1_inst (
        .clk     (clk),
        .rstn    (rstn),
        .ms_line (ms_line),
        .sl_out  (sl_out_1),
        .mem     (mem_1.slave)
    );

    serial_slave #(
        .ADDR_W  (ADDR_W),
        .DATA_W  (DATA_W),
        .SELF_ID (slave_id_t'(2))
    ) slave_2_inst (
        .clk     (clk),
        .rstn    (rstn),
        .ms_line (ms_line),
        .sl_out  (sl_out_2),
        .mem     (mem_2.slave)
    );

    slave_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_1_inst (
        .clk  (clk),
        .rstn (rstn),
        .port (mem_1.memory)
    );

    slave_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_2_inst (
        .clk  (clk),
        .rstn (rstn),
        .port (mem_2.memory)
    );

endmodule

// ==== verif/serbus_assert.sv ====
// APB and line assertions
`timescale 1ns/1ps

module serbus_assert #(
    parameter int ADDR_W = 6
) (
    input logic                               clk,
    input logic                               rstn,
    input logic                               psel,
    input logic                               penable,
    input logic [serbus_pkg::ID_W+ADDR_W-1:0] paddr,
    input logic                               pready,
    input logic                               pslverr,
    input logic                               ms_line
);

    import serbus_pkg::*;

    slave_id_t req_id;

    assign req_id = paddr[ID_W+ADDR_W-1 -: ID_W];

    // pready only in the access phase.
    assert property (@(posedge clk) disable iff (!rstn) pready |-> (psel && penable))
        else $error("pready raised outside the APB access phase");

    // errors only with pready, and only where no slave answers.
    assert property (@(posedge clk) disable iff (!rstn)
            pslverr |-> (pready && req_id != slave_id_t'(1) && req_id != slave_id_t'(2)))
        else $error("pslverr without pready or for an existing slave");

    assert property (@(posedge clk) disable iff (!rstn) pready |=> !pready)
        else $error("pready held for more than one cycle");

    // downstream line idles between transfers.
    assert property (@(posedge clk) disable iff (!rstn) !psel |-> ms_line)
        else $error("ms_line left idle level while psel low");

endmodule

bind serbus_top serbus_assert #(.ADDR_W(ADDR_W)) serbus_assert_inst (
    .clk     (clk),
    .rstn    (rstn),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pready  (pready),
    .pslverr (pslverr),
    .ms_line (ms_line)
);

// ==== verif/serbus_tb.sv ====
// Serial bus testbench
`timescale 1ns/1ps

module serbus_tb;

    import serbus_pkg::*;

    localparam int ADDR_W        = 6;
    localparam int DATA_W        = 8;
    localparam int DEPTH         = 1 << ADDR_W;
    localparam int READY_TIMEOUT = 500;

    logic                   clk;
    logic                   rstn;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [ID_W+ADDR_W-1:0] paddr;
    logic [DATA_W-1:0]      pwdata;
    logic [DATA_W-1:0]      prdata;
    logic                   pready;
    logic                   pslverr;

    logic [DATA_W-1:0] model [8][DEPTH];    // indexed by slave identity.
    logic [DATA_W-1:0] exp_data;
    logic              exp_err;
    logic              exp_read;
    logic [DATA_W-1:0] patterns [3] = '{8'hFF, 8'h55, 8'hAA};
    int                check_count = 0;
    int                error_count = 0;
    integer            seed = 74;

    serbus_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) serbus_top_inst (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected {pslverr, prdata} for one transfer; writes update the model.
    function automatic logic [DATA_W:0] model_access(input logic wr, input slave_id_t id,
            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic [DATA_W:0] result;
        result = '0;
        if (id != 3'd1 && id != 3'd2) begin
            result = {1'b1, {DATA_W{1'b0}}};   // nobody answers.
        end else if (wr) begin
            model[id][addr] = wdata;
        end else begin
            result = {1'b0, model[id][addr]};
        end
        return result;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic apb_transfer(input logic wr, input slave_id_t id,
            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        int              waited;
        logic [DATA_W:0] expected;
        expected = model_access(wr, id, addr, wdata);
        exp_err  = expected[DATA_W];
        exp_data = expected[DATA_W-1:0];
        exp_read = !wr;
        psel     = 1'b1;   // setup phase.
        penable  = 1'b0;
        pwrite   = wr;
        paddr    = {id, addr};
        pwdata   = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!pready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            $display("timeout: no pready within %0d cycles of an APB transfer", READY_TIMEOUT);
            $display("Simulation failed");
            $finish;
        end else begin
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    // compares every completed transfer against the model.
    always @(negedge clk) begin
        if (rstn && pready) begin
            check_value("pslverr", 32'(pslverr), 32'(exp_err));
            if (exp_read || exp_err) begin
                check_value("prdata", 32'(prdata), 32'(exp_data));
            end
        end
    end

    initial begin
        logic [31:0] r;
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        exp_data = '0;
        exp_err  = 1'b0;
        exp_read = 1'b0;
        for (int s = 0; s < 8; s++) begin
            for (int a = 0; a < DEPTH; a++) begin
                model[s][a] = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        @(posedge clk);
        #1;

        // memories start cleared.
        for (int a = 0; a < DEPTH; a += 9) begin
            apb_transfer(1'b0, 3'd1, ADDR_W'(a), 8'h00);
            apb_transfer(1'b0, 3'd2, ADDR_W'(a), 8'h00);
        end

        apb_transfer(1'b1, 3'd1, 6'd5, 8'h3C);
        apb_transfer(1'b0, 3'd1, 6'd5, 8'h00);

        // slaves keep separate memories.
        apb_transfer(1'b1, 3'd2, 6'd5, 8'hC3);
        apb_transfer(1'b0, 3'd1, 6'd5, 8'h00);
        apb_transfer(1'b1, 3'd1, 6'd12, 8'h5A);
        apb_transfer(1'b0, 3'd2, 6'd12, 8'h00);
        apb_transfer(1'b0, 3'd2, 6'd5, 8'h00);

        // unknown identities time out.
        apb_transfer(1'b1, 3'd0, 6'd5, 8'hFF);
        apb_transfer(1'b0, 3'd3, 6'd5, 8'h00);
        apb_transfer(1'b1, 3'd7, 6'd12, 8'hFF);
        apb_transfer(1'b0, 3'd1, 6'd5, 8'h00);
        apb_transfer(1'b0, 3'd2, 6'd5, 8'h00);
        apb_transfer(1'b0, 3'd1, 6'd12, 8'h00);

        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            apb_transfer(r[0], r[1] ? 3'd2 : 3'd1, r[2 +: ADDR_W], r[16 +: DATA_W]);
        end

        // msb-first order end to end.
        for (int p = 0; p < 3; p++) begin
            apb_transfer(1'b1, 3'd1, 6'd63, patterns[p]);
            apb_transfer(1'b0, 3'd1, 6'd63, 8'h00);
            apb_transfer(1'b1, 3'd2, 6'd0, patterns[p]);
            apb_transfer(1'b0, 3'd2, 6'd0, 8'h00);
        end

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/serbus_pkg.sv
common/mem_port_if.sv
logic/bit_shifter.sv
logic/slave_mem.sv
serial_master/serial_master.sv
serial_slave/serial_slave.sv
logic/serbus_top.sv
verif/serbus_assert.sv
verif/serbus_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = serbus_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
